// File: memory_hierarchy.f
verilog/cache_pkg.sv
verilog/dcache.sv
verilog/icache.sv
verilog/mem_arbiter.sv
verilog/main_mem.sv
verilog/memory_hierarchy.sv
tests/memory_hierarchy_props.sv
tests/memory_hierarchy_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the memory hierarchy testbench with verilator and run it
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module memory_hierarchy_tb \
  -f memory_hierarchy.f \
  -o memory_hierarchy_sim > build.log 2>&1 \
  && ./obj_dir/memory_hierarchy_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// File: tests/memory_hierarchy_tb.sv
////////////////////
// memory_hierarchy_tb
// drives the core data and instr ports, keeps a reference
// memory and checks every returned word against it
////////////////////
`timescale 1ns/1ps

module memory_hierarchy_tb;

  localparam int MEM_WORDS = 1024;
  localparam int LIMIT     = 200;  // cycles allowed per request

  logic             CLK;
  logic             nRST;
  cache_pkg::dreq_t dreq;
  cache_pkg::drsp_t drsp;
  cache_pkg::ireq_t ireq;
  cache_pkg::irsp_t irsp;

  cache_pkg::word_t model [MEM_WORDS] = '{default: '0};  // reference memory starting at zero
  integer seed;
  string  test_name;
  int     cmp_checks;    // owned by the compare process
  int     cmp_errors;
  int     extra_errors;  // timing checks in the main sequence
  int     checks_at_start;
  int     errors_at_start;
  int     tests_run;
  int     waited;        // cycles the last request took

  memory_hierarchy #(
    .MEM_LATENCY (3),
    .MEM_WORDS   (MEM_WORDS)
  ) dut0 (
    .CLK  (CLK),
    .nRST (nRST),
    .dreq (dreq),
    .drsp (drsp),
    .ireq (ireq),
    .irsp (irsp)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;  // 100 ns period
  end

  // expected load word from the 4 KB word-addressed model
  function automatic cache_pkg::word_t ref_load(input cache_pkg::word_t addr);
    return model[addr[11:2]];
  endfunction

  // compare process sees the values from before the clock edge
  always @(posedge CLK) begin
    if (nRST && drsp.hit) begin
      if (dreq.ren) begin
        cmp_checks++;
        if (drsp.load !== ref_load(dreq.addr)) begin
          cmp_errors++;
          $display("error %s: data load at %h, expected %h, actual %h",
                   test_name, dreq.addr, ref_load(dreq.addr), drsp.load);
        end
      end
      if (dreq.wen)
        model[dreq.addr[11:2]] = dreq.wdata;  // store lands in the hit cycle
    end
    if (nRST && irsp.hit && ireq.ren) begin
      cmp_checks++;
      if (irsp.instr !== ref_load(ireq.addr)) begin
        cmp_errors++;
        $display("error %s: instr fetch at %h, expected %h, actual %h",
                 test_name, ireq.addr, ref_load(ireq.addr), irsp.instr);
      end
    end
  end

  // hold data and/or instr request until each side reports hit
  task automatic issue(input logic d_go, input logic d_wr, input cache_pkg::word_t d_addr,
                       input cache_pkg::word_t d_data, input logic i_go,
                       input cache_pkg::word_t i_addr, output int cycles);
    logic d_done;
    logic i_done;
    d_done = !d_go;
    i_done = !i_go;
    cycles = 0;
    @(negedge CLK);
    dreq.ren   = d_go && !d_wr;
    dreq.wen   = d_go && d_wr;
    dreq.addr  = d_addr;
    dreq.wdata = d_data;
    ireq.ren   = i_go;
    ireq.addr  = i_addr;
    while (!(d_done && i_done) && cycles < LIMIT) begin
      @(posedge CLK);
      cycles++;
      if (drsp.hit)
        d_done = 1'b1;
      if (irsp.hit)
        i_done = 1'b1;
      @(negedge CLK);
      if (d_done)
        dreq = '0;  // core moves on after its hit cycle
      if (i_done)
        ireq = '0;
    end
    if (!(d_done && i_done)) begin
      $display("timeout in %s: data %h or instr %h got no hit within %0d cycles",
               test_name, d_addr, i_addr, LIMIT);
      $display("TB FAILED");
      $finish;
    end
  endtask

  task automatic store_word(input cache_pkg::word_t addr, input cache_pkg::word_t data);
    issue(1'b1, 1'b1, addr, data, 1'b0, '0, waited);
  endtask

  task automatic load_word(input cache_pkg::word_t addr);
    issue(1'b1, 1'b0, addr, '0, 1'b0, '0, waited);
  endtask

  task automatic fetch_instr(input cache_pkg::word_t addr);
    issue(1'b0, 1'b0, '0, '0, 1'b1, addr, waited);
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    checks_at_start = cmp_checks;
    errors_at_start = cmp_errors + extra_errors;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s finished: %0d checks, %0d errors", test_name,
             cmp_checks - checks_at_start, cmp_errors + extra_errors - errors_at_start);
  endtask

  initial begin
    cache_pkg::word_t t1_addr [4];
    logic [31:0]      r;
    cache_pkg::word_t da;
    cache_pkg::word_t ia;
    t1_addr      = '{32'h100, 32'h104, 32'h208, 32'h30c};
    seed         = 32'hda5c_3896;
    nRST         = 1'b0;
    dreq         = '0;
    ireq         = '0;
    cmp_checks   = 0;
    cmp_errors   = 0;
    extra_errors = 0;
    tests_run    = 0;
    test_name    = "reset";
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    // test 1 checks cold zeros and then reads back each store
    start_test("read_after_write");
    foreach (t1_addr[i])
      load_word(t1_addr[i]);
    foreach (t1_addr[i])
      store_word(t1_addr[i], $random(seed));
    foreach (t1_addr[i])
      load_word(t1_addr[i]);
    end_test();

    // test 2 puts three tags in set 5 so the third store evicts a dirty line
    start_test("writeback_evict");
    store_word(32'h128, $random(seed));  // tag 4
    store_word(32'h168, $random(seed));  // tag 5
    store_word(32'h1a8, $random(seed));  // tag 6 evicts tag 4
    load_word(32'h128);
    load_word(32'h12c);                  // untouched word of the same block
    load_word(32'h168);
    load_word(32'h1a8);
    end_test();

    // test 3 checks lru order in set 2
    start_test("lru_order");
    store_word(32'h510, $random(seed));  // A
    store_word(32'h550, $random(seed));  // B
    load_word(32'h510);                  // A touched again so B is lru
    store_word(32'h590, $random(seed));  // C replaces B
    load_word(32'h510);
    if (waited != 1) begin
      extra_errors++;
      $display("error %s: line A was replaced, its read took %0d cycles instead of 1",
               test_name, waited);
    end
    load_word(32'h550);                  // B refetched
    load_word(32'h590);
    end_test();

    // test 4 fetches zeros and lines the data cache wrote back
    start_test("instr_fetch");
    fetch_instr(32'h800);
    fetch_instr(32'h9f0);
    fetch_instr(32'hffc);
    fetch_instr(32'h128);  // evicted in test 2
    fetch_instr(32'h168);
    fetch_instr(32'h168);  // now an icache hit
    end_test();

    // test 5 races random data traffic against instr reads
    start_test("concurrent");
    repeat (40) begin
      r  = $random(seed);
      da = $random(seed) & 32'h7fc;            // data stays in the low 2 KB
      ia = 32'h800 | ($random(seed) & 32'h7fc);  // instr region never stored
      issue(1'b1, r[0], da, $random(seed), 1'b1, ia, waited);
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests_run, cmp_checks,
             cmp_errors + extra_errors);
    if (cmp_errors + extra_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: tests/memory_hierarchy_props.sv
////////////////////
// memory_hierarchy_props
// arbiter grant and memory handshake assertions bound into mem_arbiter
////////////////////
`timescale 1ns/1ps

module memory_hierarchy_props (
  input logic              CLK,
  input logic              nRST,
  input cache_pkg::mreq_t  dmreq,
  input cache_pkg::mrsp_t  dmrsp,
  input cache_pkg::mreq_t  imreq,
  input cache_pkg::mrsp_t  imrsp,
  input cache_pkg::mreq_t  mreq,
  input cache_pkg::mrsp_t  mrsp,
  input cache_pkg::owner_e owner
);

  logic d_en;
  logic i_en;
  logic m_en;

  assign d_en = dmreq.ren | dmreq.wen;
  assign i_en = imreq.ren | imreq.wen;
  assign m_en = mreq.ren | mreq.wen;  // request as seen by memory

  // wait reaches a cache low only while its own request sits at the memory
  data_xfer: assert property (@(posedge CLK) disable iff (!nRST)
    !dmrsp.mwait |-> (d_en && m_en && (mreq == dmreq)))
    else $error("data cache saw wait low without its request at the memory");

  instr_xfer: assert property (@(posedge CLK) disable iff (!nRST)
    !imrsp.mwait |-> (i_en && m_en && (mreq == imreq)))
    else $error("instr cache saw wait low without its request at the memory");

  // grant held for the whole burst
  data_lock: assert property (@(posedge CLK) disable iff (!nRST)
    (owner == cache_pkg::OWN_DATA && d_en) |=> (owner == cache_pkg::OWN_DATA))
    else $error("data cache lost its grant while enable was high");

  instr_lock: assert property (@(posedge CLK) disable iff (!nRST)
    (owner == cache_pkg::OWN_INSTR && i_en) |=> (owner == cache_pkg::OWN_INSTR))
    else $error("instr cache lost its grant while enable was high");

  // no change of request until the word moves
  mem_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (m_en && mrsp.mwait) |=> (m_en && $stable(mreq.addr)))
    else $error("memory request changed while wait was high");

endmodule

bind mem_arbiter memory_hierarchy_props props0 (
  .CLK   (CLK),
  .nRST  (nRST),
  .dmreq (dmreq),
  .dmrsp (dmrsp),
  .imreq (imreq),
  .imrsp (imrsp),
  .mreq  (mreq),
  .mrsp  (mrsp),
  .owner (owner)
);

// File: verilog/memory_hierarchy.sv
////////////////////
// memory_hierarchy
// data and instr caches sharing one main memory via the arbiter
////////////////////
`timescale 1ns/1ps

module memory_hierarchy #(
  parameter int MEM_LATENCY = 3,
  parameter int MEM_WORDS   = 1024
) (
  input  logic             CLK,
  input  logic             nRST,
  input  cache_pkg::dreq_t dreq,
  output cache_pkg::drsp_t drsp,
  input  cache_pkg::ireq_t ireq,
  output cache_pkg::irsp_t irsp
);

  cache_pkg::mreq_t d_mreq, i_mreq, m_mreq;
  cache_pkg::mrsp_t d_mrsp, i_mrsp, m_mrsp;

  dcache dcache0 (
    .CLK  (CLK),
    .nRST (nRST),
    .dreq (dreq),
    .drsp (drsp),
    .mreq (d_mreq),
    .mrsp (d_mrsp)
  );

  icache icache0 (
    .CLK  (CLK),
    .nRST (nRST),
    .ireq (ireq),
    .irsp (irsp),
    .mreq (i_mreq),
    .mrsp (i_mrsp)
  );

  mem_arbiter arb0 (
    .CLK   (CLK),
    .nRST  (nRST),
    .dmreq (d_mreq),
    .dmrsp (d_mrsp),
    .imreq (i_mreq),
    .imrsp (i_mrsp),
    .mreq  (m_mreq),
    .mrsp  (m_mrsp)
  );

  main_mem #(
    .MEM_LATENCY (MEM_LATENCY),
    .MEM_WORDS   (MEM_WORDS)
  ) mem0 (
    .CLK  (CLK),
    .nRST (nRST),
    .mreq (m_mreq),
    .mrsp (m_mrsp)
  );

endmodule

// File: verilog/main_mem.sv
////////////////////
// main_mem
// word memory with a fixed answer latency, zero at start
////////////////////
`timescale 1ns/1ps

module main_mem #(
  parameter int MEM_LATENCY = 3,
  parameter int MEM_WORDS   = 1024
) (
  input  logic             CLK,
  input  logic             nRST,
  input  cache_pkg::mreq_t mreq,
  output cache_pkg::mrsp_t mrsp
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam int CW = $clog2(MEM_LATENCY + 1);

  cache_pkg::word_t mem [MEM_WORDS];

  logic          en, en_q;
  logic [31:0]   addr_q;
  logic          new_req;
  logic          served;   // word already moved for this request
  logic          xfer;
  logic [CW-1:0] cnt;
  logic [AW-1:0] widx;

  assign en      = mreq.ren | mreq.wen;
  assign new_req = en && (!en_q || (mreq.addr != addr_q));  // rise or addr change
  assign widx    = mreq.addr[2 +: AW];  // upper bits dropped
  assign xfer    = en && !new_req && (cnt == '0) && !served;

  assign mrsp.mwait = ~xfer;
  assign mrsp.load  = mem[widx];

  initial begin
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = '0;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      en_q   <= 1'b0;
      addr_q <= '0;
      cnt    <= '0;
      served <= 1'b0;
    end else begin
      en_q   <= en;
      addr_q <= mreq.addr;
      if (new_req) begin
        cnt    <= CW'(MEM_LATENCY - 1);  // wait drops latency cycles on
        served <= 1'b0;
      end else begin
        if (cnt != '0)
          cnt <= cnt - 1'b1;
        if (xfer)
          served <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (xfer && mreq.wen)
      mem[widx] <= mreq.wdata;
  end

endmodule

// File: verilog/mem_arbiter.sv
////////////////////
// mem_arbiter
// hands the single memory port to one cache at a time,
// data side wins ties, grant locked while enable stays high
////////////////////
`timescale 1ns/1ps

module mem_arbiter (
  input  logic             CLK,
  input  logic             nRST,
  input  cache_pkg::mreq_t dmreq,   // from data cache
  output cache_pkg::mrsp_t dmrsp,
  input  cache_pkg::mreq_t imreq,   // from instr cache
  output cache_pkg::mrsp_t imrsp,
  output cache_pkg::mreq_t mreq,    // to memory
  input  cache_pkg::mrsp_t mrsp
);

  cache_pkg::owner_e owner, next_owner;

  logic d_en;
  logic i_en;

  assign d_en = dmreq.ren | dmreq.wen;
  assign i_en = imreq.ren | imreq.wen;

  // grant and lock
  always_comb begin
    next_owner = owner;
    case (owner)
      cache_pkg::OWN_NONE: begin
        if (d_en)
          next_owner = cache_pkg::OWN_DATA;   // data priority
        else if (i_en)
          next_owner = cache_pkg::OWN_INSTR;
      end
      cache_pkg::OWN_DATA: begin
        if (!d_en)
          next_owner = cache_pkg::OWN_NONE;   // burst over
      end
      cache_pkg::OWN_INSTR: begin
        if (!i_en)
          next_owner = cache_pkg::OWN_NONE;
      end
      default: next_owner = cache_pkg::OWN_NONE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      owner <= cache_pkg::OWN_NONE;
    else
      owner <= next_owner;
  end

  // request mux, nothing reaches memory while ungranted
  always_comb begin
    case (owner)
      cache_pkg::OWN_DATA:  mreq = dmreq;
      cache_pkg::OWN_INSTR: mreq = imreq;
      default:              mreq = '0;
    endcase
  end

  // response routing
  // the loser just sees wait high, its request stays pending
  always_comb begin
    dmrsp.load  = mrsp.load;
    imrsp.load  = mrsp.load;
    dmrsp.mwait = 1'b1;
    imrsp.mwait = 1'b1;
    if (owner == cache_pkg::OWN_DATA)
      dmrsp.mwait = mrsp.mwait;
    if (owner == cache_pkg::OWN_INSTR)
      imrsp.mwait = mrsp.mwait;
  end

endmodule

// File: verilog/icache.sv
////////////////////
// icache
// direct-mapped read-only instruction cache,
// 16 one-word entries, single word fill on a miss
////////////////////
`timescale 1ns/1ps

module icache (
  input  logic             CLK,
  input  logic             nRST,
  input  cache_pkg::ireq_t ireq,
  output cache_pkg::irsp_t irsp,
  output cache_pkg::mreq_t mreq,
  input  cache_pkg::mrsp_t mrsp
);

  cache_pkg::istate_e state, next_state;
  cache_pkg::iaddr_t  addr;

  logic [cache_pkg::ITAG_W-1:0] tags [cache_pkg::ISETS];
  cache_pkg::word_t             data [cache_pkg::ISETS];
  logic [cache_pkg::ISETS-1:0]  valid;

  logic match;
  logic fill_done;

  assign addr      = cache_pkg::iaddr_t'(ireq.addr);
  assign match     = valid[addr.idx] && (tags[addr.idx] == addr.tag);
  assign fill_done = (state == cache_pkg::I_FILL) && ~mrsp.mwait;

  // core side
  assign irsp.hit   = (state == cache_pkg::I_IDLE) && ireq.ren && match;
  assign irsp.instr = data[addr.idx];

  // one word read while filling
  always_comb begin
    mreq       = '0;
    mreq.ren   = (state == cache_pkg::I_FILL);
    mreq.addr  = {addr.tag, addr.idx, 2'b00};  // word aligned
  end

  always_comb begin
    next_state = state;
    case (state)
      cache_pkg::I_IDLE: if (ireq.ren && !match) next_state = cache_pkg::I_FILL;
      cache_pkg::I_FILL: if (fill_done) next_state = cache_pkg::I_IDLE;
      default: next_state = cache_pkg::I_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= cache_pkg::I_IDLE;
      valid <= '0;
    end else begin
      state <= next_state;
      if (fill_done)
        valid[addr.idx] <= 1'b1;
    end
  end

  // entry payload
  always_ff @(posedge CLK) begin
    if (fill_done) begin
      data[addr.idx] <= mrsp.load;
      tags[addr.idx] <= addr.tag;
    end
  end

endmodule

// File: verilog/dcache.sv
////////////////////
// dcache
// two-way set associative write-back data cache, lru per set,
// two-word blocks, dirty victim written back before the fetch
////////////////////
`timescale 1ns/1ps

module dcache (
  input  logic             CLK,
  input  logic             nRST,
  input  cache_pkg::dreq_t dreq,
  output cache_pkg::drsp_t drsp,
  output cache_pkg::mreq_t mreq,
  input  cache_pkg::mrsp_t mrsp
);

  cache_pkg::dstate_e state, next_state;
  cache_pkg::daddr_t  addr;

  // storage, no reset on tags and words
  logic [cache_pkg::DTAG_W-1:0] tags [cache_pkg::DSETS][cache_pkg::DWAYS];
  cache_pkg::word_t             data [cache_pkg::DSETS][cache_pkg::DWAYS][2];

  // control bits
  logic [cache_pkg::DSETS-1:0][cache_pkg::DWAYS-1:0] valid;
  logic [cache_pkg::DSETS-1:0][cache_pkg::DWAYS-1:0] dirty;
  logic [cache_pkg::DSETS-1:0]                        lru;  // way to evict next

  logic access;    // core wants something
  logic hit_any;
  logic hit_way;
  logic victim;
  logic blk_sel;   // which word of the block is on the bus
  logic done;      // memory word moved this cycle
  logic fetching;

  assign addr    = cache_pkg::daddr_t'(dreq.addr);
  assign access  = dreq.ren | dreq.wen;
  assign victim  = lru[addr.idx];  // stable for the whole miss, lru only moves on hits
  assign blk_sel = (state == cache_pkg::D_WB1) || (state == cache_pkg::D_FETCH1);
  assign done    = ~mrsp.mwait;
  assign fetching = (state == cache_pkg::D_FETCH0) || (state == cache_pkg::D_FETCH1);

  // tag compare across both ways
  always_comb begin
    hit_any = 1'b0;
    hit_way = 1'b0;
    for (int w = 0; w < cache_pkg::DWAYS; w++) begin
      if (valid[addr.idx][w] && (tags[addr.idx][w] == addr.tag)) begin
        hit_any = 1'b1;
        hit_way = 1'(w);
      end
    end
  end

  // core response, hit only while idle
  assign drsp.hit  = (state == cache_pkg::D_IDLE) && access && hit_any;
  assign drsp.load = data[addr.idx][hit_way][addr.blkoff];

  // memory request, enable held from first wb word to last fetch word
  always_comb begin
    mreq = '0;
    case (state)
      cache_pkg::D_WB0, cache_pkg::D_WB1: begin
        mreq.wen   = 1'b1;
        mreq.addr  = {tags[addr.idx][victim], addr.idx, blk_sel, 2'b00};  // victim's own address
        mreq.wdata = data[addr.idx][victim][blk_sel];
      end
      cache_pkg::D_FETCH0, cache_pkg::D_FETCH1: begin
        mreq.ren  = 1'b1;
        mreq.addr = {addr.tag, addr.idx, blk_sel, 2'b00};
      end
      default: mreq = '0;
    endcase
  end

  // next state
  always_comb begin
    next_state = state;
    case (state)
      cache_pkg::D_IDLE: begin
        if (access && !hit_any) begin
          if (valid[addr.idx][victim] && dirty[addr.idx][victim])
            next_state = cache_pkg::D_WB0;    // dirty miss
          else
            next_state = cache_pkg::D_FETCH0; // clean miss
        end
      end
      cache_pkg::D_WB0:    if (done) next_state = cache_pkg::D_WB1;
      cache_pkg::D_WB1:    if (done) next_state = cache_pkg::D_FETCH0;
      cache_pkg::D_FETCH0: if (done) next_state = cache_pkg::D_FETCH1;
      cache_pkg::D_FETCH1: if (done) next_state = cache_pkg::D_IDLE;  // held request hits next
      default: next_state = cache_pkg::D_IDLE;
    endcase
  end

  // control state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= cache_pkg::D_IDLE;
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      state <= next_state;
      if (drsp.hit) begin
        lru[addr.idx] <= ~hit_way;  // other way is now lru
        if (dreq.wen)
          dirty[addr.idx][hit_way] <= 1'b1;
      end
      if ((state == cache_pkg::D_WB1) && done)
        dirty[addr.idx][victim] <= 1'b0;  // victim safely in memory
      if ((state == cache_pkg::D_FETCH0) && done)
        valid[addr.idx][victim] <= 1'b0;  // half-filled line, keep it invisible
      if ((state == cache_pkg::D_FETCH1) && done) begin
        valid[addr.idx][victim] <= 1'b1;
        dirty[addr.idx][victim] <= 1'b0;
      end
    end
  end

  // data and tag arrays
  always_ff @(posedge CLK) begin
    if (drsp.hit && dreq.wen)
      data[addr.idx][hit_way][addr.blkoff] <= dreq.wdata;
    if (fetching && done)
      data[addr.idx][victim][blk_sel] <= mrsp.load;
    if ((state == cache_pkg::D_FETCH1) && done)
      tags[addr.idx][victim] <= addr.tag;
  end

endmodule

// File: verilog/cache_pkg.sv
////////////////////
// cache_pkg
// shared types for the memory hierarchy: address layouts,
// core and memory request/response structs, state enums
////////////////////

package cache_pkg;

  // geometry
  localparam int DSETS  = 8;   // data cache sets
  localparam int DWAYS  = 2;   // data cache ways
  localparam int ISETS  = 16;  // instr cache entries
  localparam int DTAG_W = 26;
  localparam int ITAG_W = 26;

  typedef logic [31:0] word_t;

  // data cache view of a byte address
  typedef struct packed {
    logic [DTAG_W-1:0] tag;
    logic [2:0]        idx;     // set index
    logic              blkoff;  // word within block
    logic [1:0]        bytoff;
  } daddr_t;

  // instr cache view, one word per entry
  typedef struct packed {
    logic [ITAG_W-1:0] tag;
    logic [3:0]        idx;
    logic [1:0]        bytoff;
  } iaddr_t;

  // core data port
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t wdata;  // store word
  } dreq_t;

  typedef struct packed {
    logic  hit;
    word_t load;
  } drsp_t;

  // core instr port
  typedef struct packed {
    logic  ren;
    word_t addr;
  } ireq_t;

  typedef struct packed {
    logic  hit;
    word_t instr;
  } irsp_t;

  // memory side, cache->arbiter and arbiter->memory
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;   // byte address
    word_t wdata;
  } mreq_t;

  typedef struct packed {
    logic  mwait;  // high until the word moves
    word_t load;
  } mrsp_t;

  typedef enum logic [2:0] {D_IDLE, D_WB0, D_WB1, D_FETCH0, D_FETCH1} dstate_e;
  typedef enum logic {I_IDLE, I_FILL} istate_e;
  typedef enum logic [1:0] {OWN_NONE, OWN_DATA, OWN_INSTR} owner_e;

endpackage
